/* design/flicker_blend.sv */
////////////////////////////////////////////////////////////
// Flicker blender
// Mixes the shown frame with earlier frames into 8-bit RGB
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module flicker_blend (
	input  logic                        clk_sys,
	input  logic                        rst,
	input  logic                        ce_pix,
	input  logic                        hs,
	input  logic                        vs,
	input  logic                        hbl,
	input  logic                        vbl,
	input  logic                        frame_end,
	input  lynx_video_pkg::bank_t       newest_bank,
	input  lynx_video_pkg::bank_rd_t    bank_rd,
	input  lynx_video_pkg::blend_mode_t blend_mode,
	output lynx_video_pkg::video_out_t  video
);

	lynx_video_pkg::bank_t       shown_bank;
	lynx_video_pkg::bank_t       last_bank;
	lynx_video_pkg::blend_mode_t mode_q;
	lynx_video_pkg::rgb444_t     rgb_now;
	lynx_video_pkg::rgb444_t     rgb_last;
	lynx_video_pkg::rgb888_t     rgb_mix;

	function automatic lynx_video_pkg::rgb444_t pick(
		input lynx_video_pkg::bank_rd_t rd,
		input lynx_video_pkg::bank_t    idx
	);
		case (idx)
			2'd1:    return rd.bank1;
			2'd2:    return rd.bank2;
			default: return rd.bank0;
		endcase
	endfunction

	// One colour channel, 4-bit inputs to 8-bit output
	function automatic logic [7:0] blend_chan(
		input lynx_video_pkg::blend_mode_t mode,
		input logic [3:0]                  now_v,
		input logic [3:0]                  last_v,
		input logic [3:0]                  v0,
		input logic [3:0]                  v1,
		input logic [3:0]                  v2
	);
		logic [4:0]  sum2;
		logic [5:0]  sum3;
		logic [7:0]  wide3;
		logic [23:0] prod;
		sum2  = {1'b0, now_v} + {1'b0, last_v};
		sum3  = {2'b00, v0} + {2'b00, v1} + {2'b00, v2};
		wide3 = {sum3, sum3[5:4]};
		prod  = 24'(wide3) * 24'(lynx_video_pkg::BLEND3_MUL);
		case (mode)
			lynx_video_pkg::BLEND_TWO:   return {sum2, sum2[4:2]};
			lynx_video_pkg::BLEND_THREE: return 8'(prod >> lynx_video_pkg::BLEND3_SHIFT);
			default:                     return {now_v, now_v};
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// Bank selection, updated once per raster frame
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			shown_bank <= '0;
			last_bank  <= '0;
			mode_q     <= lynx_video_pkg::BLEND_OFF;
		end else if (frame_end) begin
			shown_bank <= newest_bank;
			last_bank  <= shown_bank;
			mode_q     <= blend_mode;
		end
	end

	assign rgb_now  = pick(bank_rd, shown_bank);
	assign rgb_last = pick(bank_rd, last_bank);

	always_comb begin
		rgb_mix.r = blend_chan(mode_q, rgb_now[11:8], rgb_last[11:8],
			bank_rd.bank0[11:8], bank_rd.bank1[11:8], bank_rd.bank2[11:8]);
		rgb_mix.g = blend_chan(mode_q, rgb_now[7:4], rgb_last[7:4],
			bank_rd.bank0[7:4], bank_rd.bank1[7:4], bank_rd.bank2[7:4]);
		rgb_mix.b = blend_chan(mode_q, rgb_now[3:0], rgb_last[3:0],
			bank_rd.bank0[3:0], bank_rd.bank1[3:0], bank_rd.bank2[3:0]);
	end

	////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			video.ce_pix <= 1'b0;
			video.hs     <= 1'b0;
			video.vs     <= 1'b0;
			video.hbl    <= 1'b1;
			video.vbl    <= 1'b1;
			video.rgb    <= '0;
		end else begin
			video.ce_pix <= ce_pix;
			if (ce_pix) begin
				video.hs  <= hs;
				video.vs  <= vs;
				video.hbl <= hbl;
				video.vbl <= vbl;
				video.rgb <= rgb_mix;
			end
		end
	end

endmodule

/* design/frame_ram.sv */
////////////////////////////////////////////////////////////
// Frame memory bank
// Simple dual port RAM with a registered read
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module frame_ram #(
	parameter int DEPTH = lynx_video_pkg::FRAME_PIXELS
) (
	input  logic                      clk_sys,
	input  logic                      we,
	input  lynx_video_pkg::pix_addr_t waddr,
	input  lynx_video_pkg::rgb444_t   wdata,
	input  lynx_video_pkg::pix_addr_t raddr,
	output lynx_video_pkg::rgb444_t   rdata
);

	lynx_video_pkg::rgb444_t mem [DEPTH];

	// Write side, fed by the console
	always_ff @(posedge clk_sys) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Read side, one clock of latency
	always_ff @(posedge clk_sys) begin
		rdata <= mem[raddr];
	end

endmodule

/* design/frame_store.sv */
////////////////////////////////////////////////////////////
// Triple buffered frame store
// Rotates the write bank per completed frame and reads all banks
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module frame_store (
	input  logic                      clk_sys,
	input  logic                      rst,
	input  logic                      pix_valid,
	input  lynx_video_pkg::pix_wr_t   pix,
	input  logic                      buffer_en,
	input  lynx_video_pkg::pix_addr_t rd_addr,
	output lynx_video_pkg::bank_rd_t  bank_rd,
	output lynx_video_pkg::bank_t     newest_bank
);

	lynx_video_pkg::bank_t   wr_bank;
	logic                    frame_done;
	lynx_video_pkg::rgb444_t rd_word [lynx_video_pkg::BANK_COUNT];

	// Last pixel of a frame closes it
	assign frame_done = pix_valid &&
		(pix.addr == lynx_video_pkg::pix_addr_t'(lynx_video_pkg::FRAME_PIXELS - 1));

	////////////////////////////////////////////////////////////
	// Bank rotation
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wr_bank     <= '0;
			newest_bank <= '0;
		end else if (!buffer_en) begin
			// Unbuffered, everything lives in bank 0
			wr_bank     <= '0;
			newest_bank <= '0;
		end else if (frame_done) begin
			newest_bank <= wr_bank;
			if (wr_bank == lynx_video_pkg::bank_t'(lynx_video_pkg::BANK_COUNT - 1)) begin
				wr_bank <= '0;
			end else begin
				wr_bank <= wr_bank + lynx_video_pkg::bank_t'(1);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Banks
	////////////////////////////////////////////////////////////
	for (genvar i = 0; i < lynx_video_pkg::BANK_COUNT; i++) begin : g_bank
		frame_ram #(
			.DEPTH(lynx_video_pkg::FRAME_PIXELS)
		) u_ram (
			.clk_sys(clk_sys),
			.we     (pix_valid && (wr_bank == lynx_video_pkg::bank_t'(i))),
			.waddr  (pix.addr),
			.wdata  (pix.rgb),
			.raddr  (rd_addr),
			.rdata  (rd_word[i])
		);
	end

	assign bank_rd.bank0 = rd_word[0];
	assign bank_rd.bank1 = rd_word[1];
	assign bank_rd.bank2 = rd_word[2];

	// Console must stay inside the frame
	a_addr_range: assert property (@(posedge clk_sys) disable iff (rst)
		pix_valid |-> (pix.addr < lynx_video_pkg::FRAME_PIXELS))
		else $error("frame_store: write address %0d out of range", pix.addr);

	a_bank_range: assert property (@(posedge clk_sys) disable iff (rst)
		wr_bank < lynx_video_pkg::BANK_COUNT)
		else $error("frame_store: write bank %0d out of range", wr_bank);

endmodule

/* design/lynx_video_pkg.sv */
////////////////////////////////////////////////////////////
// Lynx video back end shared definitions
// Frame geometry, raster timing, blend scaling and video types
////////////////////////////////////////////////////////////

package lynx_video_pkg;

	////////////////////////////////////////////////////////////
	// Frame geometry
	////////////////////////////////////////////////////////////
	localparam int FRAME_W      = 160;
	localparam int FRAME_H      = 102;
	localparam int FRAME_PIXELS = 16320;
	localparam int BANK_COUNT   = 3;

	////////////////////////////////////////////////////////////
	// Raster timing, in pixel enables and lines
	////////////////////////////////////////////////////////////
	localparam int CE_DIV         = 9;
	localparam int LINE_TOTAL     = 445;
	localparam int LINE_COUNT     = 270;
	localparam int V_ACTIVE_FIRST = 120;
	localparam int HS_START       = 350;
	localparam int HS_LEN         = 32;
	localparam int VS_FIRST       = 1;
	localparam int VS_LAST        = 4;

	// Normalisation of the three frame sum
	localparam int BLEND3_MUL   = 21845;
	localparam int BLEND3_SHIFT = 14;

	////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////
	typedef logic [11:0] rgb444_t;
	typedef logic [13:0] pix_addr_t;
	typedef logic [8:0]  coord_t;
	typedef logic [1:0]  bank_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb888_t;

	typedef enum logic [1:0] {
		BLEND_OFF   = 2'd0,
		BLEND_TWO   = 2'd1,
		BLEND_THREE = 2'd2
	} blend_mode_t;

	// One pixel write from the console side
	typedef struct packed {
		pix_addr_t addr;
		rgb444_t   rgb;
	} pix_wr_t;

	typedef struct packed {
		rgb444_t bank2;
		rgb444_t bank1;
		rgb444_t bank0;
	} bank_rd_t;

	typedef struct packed {
		logic    ce_pix;
		logic    hs;
		logic    vs;
		logic    hbl;
		logic    vbl;
		rgb888_t rgb;
	} video_out_t;

endpackage

/* design/lynx_video_top.sv */
////////////////////////////////////////////////////////////
// Lynx video back end
// Frame store and raster generator feeding the flicker blender
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lynx_video_top (
	input  logic                        clk_sys,
	input  logic                        rst,
	input  logic                        pix_valid,
	input  lynx_video_pkg::pix_wr_t     pix,
	input  logic                        buffer_en,
	input  lynx_video_pkg::blend_mode_t blend_mode,
	output lynx_video_pkg::video_out_t  video
);

	// Raster side
	lynx_video_pkg::pix_addr_t rd_addr;
	logic                      ce_pix;
	logic                      hs;
	logic                      vs;
	logic                      hbl;
	logic                      vbl;
	logic                      frame_end;

	// Store side
	lynx_video_pkg::bank_rd_t  bank_rd;
	lynx_video_pkg::bank_t     newest_bank;

	////////////////////////////////////////////////////////////
	// Frame store
	////////////////////////////////////////////////////////////
	frame_store u_store (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.pix_valid  (pix_valid),
		.pix        (pix),
		.buffer_en  (buffer_en),
		.rd_addr    (rd_addr),
		.bank_rd    (bank_rd),
		.newest_bank(newest_bank)
	);

	////////////////////////////////////////////////////////////
	// Raster generator
	////////////////////////////////////////////////////////////
	raster_timing u_raster (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.rd_addr  (rd_addr),
		.ce_pix   (ce_pix),
		.hs       (hs),
		.vs       (vs),
		.hbl      (hbl),
		.vbl      (vbl),
		.frame_end(frame_end)
	);

	////////////////////////////////////////////////////////////
	// Blender and output register
	////////////////////////////////////////////////////////////
	flicker_blend u_blend (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.ce_pix     (ce_pix),
		.hs         (hs),
		.vs         (vs),
		.hbl        (hbl),
		.vbl        (vbl),
		.frame_end  (frame_end),
		.newest_bank(newest_bank),
		.bank_rd    (bank_rd),
		.blend_mode (blend_mode),
		.video      (video)
	);

endmodule

/* design/raster_timing.sv */
////////////////////////////////////////////////////////////
// Raster generator
// Pixel enable, x/y counters, sync, blanking and read address
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module raster_timing (
	input  logic                      clk_sys,
	input  logic                      rst,
	output lynx_video_pkg::pix_addr_t rd_addr,
	output logic                      ce_pix,
	output logic                      hs,
	output logic                      vs,
	output logic                      hbl,
	output logic                      vbl,
	output logic                      frame_end
);

	logic [$clog2(lynx_video_pkg::CE_DIV)-1:0] div;
	lynx_video_pkg::coord_t                    x;
	lynx_video_pkg::coord_t                    y;
	logic                                      line_end;
	logic                                      last_line;

	////////////////////////////////////////////////////////////
	// Pixel enable, one clock in CE_DIV
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			div    <= '0;
			ce_pix <= 1'b0;
		end else begin
			if (div == (lynx_video_pkg::CE_DIV - 1)) begin
				div <= '0;
			end else begin
				div <= div + 1'b1;
			end
			ce_pix <= (div == (lynx_video_pkg::CE_DIV - 1));
		end
	end

	assign line_end  = (x == lynx_video_pkg::coord_t'(lynx_video_pkg::LINE_TOTAL - 1));
	assign last_line = (y == lynx_video_pkg::coord_t'(lynx_video_pkg::LINE_COUNT - 1));

	////////////////////////////////////////////////////////////
	// Raster counters
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			x <= '0;
			y <= '0;
		end else if (ce_pix) begin
			if (line_end) begin
				x <= '0;
				if (last_line) begin
					y <= '0;
				end else begin
					y <= y + lynx_video_pkg::coord_t'(1);
				end
			end else begin
				x <= x + lynx_video_pkg::coord_t'(1);
			end
		end
	end

	// Wrap of the whole raster
	assign frame_end = ce_pix && line_end && last_line;

	////////////////////////////////////////////////////////////
	// Sync and blanking decode for the current position
	////////////////////////////////////////////////////////////
	assign hbl = (x >= lynx_video_pkg::coord_t'(lynx_video_pkg::FRAME_W));
	assign vbl = (y < lynx_video_pkg::coord_t'(lynx_video_pkg::V_ACTIVE_FIRST)) ||
		(y >= lynx_video_pkg::coord_t'(lynx_video_pkg::V_ACTIVE_FIRST +
			lynx_video_pkg::FRAME_H));

	assign hs = (x >= lynx_video_pkg::coord_t'(lynx_video_pkg::HS_START)) &&
		(x < lynx_video_pkg::coord_t'(lynx_video_pkg::HS_START + lynx_video_pkg::HS_LEN));

	// Vsync edges line up with the hsync start
	assign vs = ((y == lynx_video_pkg::coord_t'(lynx_video_pkg::VS_FIRST)) &&
			(x >= lynx_video_pkg::coord_t'(lynx_video_pkg::HS_START))) ||
		((y > lynx_video_pkg::coord_t'(lynx_video_pkg::VS_FIRST)) &&
			(y < lynx_video_pkg::coord_t'(lynx_video_pkg::VS_LAST))) ||
		((y == lynx_video_pkg::coord_t'(lynx_video_pkg::VS_LAST)) &&
			(x < lynx_video_pkg::coord_t'(lynx_video_pkg::HS_START)));

	////////////////////////////////////////////////////////////
	// Read address
	////////////////////////////////////////////////////////////
	// Points at the next visible pixel, so the RAM word is ready
	// when the blender samples on the following enable
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			rd_addr <= '0;
		end else if (ce_pix) begin
			if (vbl) begin
				rd_addr <= '0;
			end else if (!hbl) begin
				if (rd_addr == lynx_video_pkg::pix_addr_t'(lynx_video_pkg::FRAME_PIXELS - 1)) begin
					rd_addr <= '0;
				end else begin
					rd_addr <= rd_addr + lynx_video_pkg::pix_addr_t'(1);
				end
			end
		end
	end

	// Frame end falls on an enable that follows a full divider period
	a_frame_end_ce: assert property (@(posedge clk_sys) disable iff (rst)
		frame_end |-> (ce_pix && $past(ce_pix, lynx_video_pkg::CE_DIV)))
		else $error("raster_timing: frame_end off the pixel enable grid");

endmodule

/* list.f */
design/lynx_video_pkg.sv
design/frame_ram.sv
design/frame_store.sv
design/raster_timing.sv
design/flicker_blend.sv
design/lynx_video_top.sv
tests/tb_lynx_video.sv

/* tests/tb_lynx_video.sv */
////////////////////////////////////////////////////////////
// Testbench for the Lynx video back end
// Writes random frames, models the banks and checks every pixel
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_lynx_video;

	localparam int     CLK_NS       = 4;
	localparam int     DRIVE_FRAMES = 7;
	localparam int     RUN_FRAMES   = DRIVE_FRAMES + 1;
	localparam longint RASTER_NS    = longint'(lynx_video_pkg::LINE_TOTAL) *
		lynx_video_pkg::LINE_COUNT * lynx_video_pkg::CE_DIV * CLK_NS;
	localparam longint WATCHDOG_NS  = RUN_FRAMES * RASTER_NS * 12 / 10;

	logic                        clk_sys;
	logic                        rst;
	logic                        pix_valid;
	lynx_video_pkg::pix_wr_t     pix;
	logic                        buffer_en;
	lynx_video_pkg::blend_mode_t blend_mode;
	lynx_video_pkg::video_out_t  video;

	// Bank model and display state
	lynx_video_pkg::rgb444_t     bank_m [lynx_video_pkg::BANK_COUNT][lynx_video_pkg::FRAME_PIXELS];
	lynx_video_pkg::bank_t       wr_m;
	lynx_video_pkg::bank_t       newest_m;
	lynx_video_pkg::bank_t       shown_m;
	lynx_video_pkg::bank_t       last_m;
	lynx_video_pkg::blend_mode_t mode_m;
	logic [31:0]                 seed;

	// Checker state
	logic                        vs_q;
	logic                        hs_q;
	logic                        hbl_q;
	int                          pix_idx;
	int                          frames_seen;
	lynx_video_pkg::coord_t      line_px;
	lynx_video_pkg::coord_t      line_cnt;
	lynx_video_pkg::coord_t      hs_cnt;

	lynx_video_top dut (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.pix_valid (pix_valid),
		.pix       (pix),
		.buffer_en (buffer_en),
		.blend_mode(blend_mode),
		.video     (video)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_NS / 2) clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Frames 0 to 2 rotate through the banks and later ones all go to bank 0
	function automatic logic frame_buffered(input int r);
		return r < 3;
	endfunction

	// Mode latched for the raster after frame r
	function automatic lynx_video_pkg::blend_mode_t frame_mode(input int r);
		case (r)
			1, 4:    return lynx_video_pkg::BLEND_TWO;
			3:       return lynx_video_pkg::BLEND_THREE;
			default: return lynx_video_pkg::BLEND_OFF;
		endcase
	endfunction

	// Expected output for frame index idx under the modelled mode
	function automatic lynx_video_pkg::rgb888_t expected_rgb(input int idx);
		lynx_video_pkg::rgb444_t cur_w;
		lynx_video_pkg::rgb444_t prev_w;
		int                      sh;
		int                      cur;
		int                      prev;
		int                      sum;
		int                      wide;
		logic [7:0]              v;
		logic [23:0]             res;
		cur_w  = bank_m[shown_m][idx];
		prev_w = bank_m[last_m][idx];
		for (int c = 0; c < 3; c++) begin
			sh   = 8 - 4 * c;
			cur  = (cur_w >> sh) & 15;
			prev = (prev_w >> sh) & 15;
			case (mode_m)
				lynx_video_pkg::BLEND_TWO: begin
					sum = cur + prev;
					v   = 8'((sum << 3) | (sum >> 2));
				end
				lynx_video_pkg::BLEND_THREE: begin
					sum = ((bank_m[0][idx] >> sh) & 15) + ((bank_m[1][idx] >> sh) & 15) +
						((bank_m[2][idx] >> sh) & 15);
					wide = (sum << 2) | (sum >> 4);
					v    = 8'((wide * lynx_video_pkg::BLEND3_MUL) >>
						lynx_video_pkg::BLEND3_SHIFT);
				end
				default: v = 8'(cur * 17);
			endcase
			res[23 - 8 * c -: 8] = v;
		end
		return lynx_video_pkg::rgb888_t'(res);
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_rgb(input string name, input lynx_video_pkg::rgb888_t got,
		input lynx_video_pkg::rgb888_t exp);
		if (got !== exp) begin
			abort_run($sformatf("ERROR %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_count(input string name, input lynx_video_pkg::coord_t got,
		input lynx_video_pkg::coord_t exp);
		if (got !== exp) begin
			abort_run($sformatf("ERROR %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("ERROR %s: got %h expected %h", name, got, exp));
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus and bank model
	////////////////////////////////////////////////////////////
	initial begin
		lynx_video_pkg::rgb444_t colour;
		rst        = 1'b1;
		pix_valid  = 1'b0;
		pix        = '0;
		buffer_en  = 1'b1;
		blend_mode = lynx_video_pkg::BLEND_OFF;
		seed       = 32'h558e;
		wr_m       = '0;
		newest_m   = '0;
		shown_m    = '0;
		last_m     = '0;
		mode_m     = lynx_video_pkg::BLEND_OFF;
		repeat (10) @(posedge clk_sys);
		rst <= 1'b0;
		@(negedge clk_sys);
		check_flag("video.ce_pix", video.ce_pix, 1'b0);
		check_flag("video.hs", video.hs, 1'b0);
		check_flag("video.vs", video.vs, 1'b0);
		check_flag("video.hbl", video.hbl, 1'b1);
		check_flag("video.vbl", video.vbl, 1'b1);
		check_rgb("video.rgb", video.rgb, '0);

		for (int r = 0; r < DRIVE_FRAMES; r++) begin
			@(posedge video.vs);
			@(posedge clk_sys);
			// A frame end has passed since the previous vsync
			if (r > 0) begin
				last_m  = shown_m;
				shown_m = newest_m;
				mode_m  = blend_mode;
			end
			buffer_en  <= frame_buffered(r);
			blend_mode <= frame_mode(r);
			if (!frame_buffered(r)) begin
				wr_m     = '0;
				newest_m = '0;
			end
			@(posedge clk_sys);
			for (int a = 0; a < lynx_video_pkg::FRAME_PIXELS; a++) begin
				seed   = lcg_next(seed);
				colour = seed[27:16];
				pix_valid <= 1'b1;
				pix.addr  <= lynx_video_pkg::pix_addr_t'(a);
				pix.rgb   <= colour;
				bank_m[wr_m][a] = colour;
				@(posedge clk_sys);
			end
			pix_valid <= 1'b0;
			if (frame_buffered(r)) begin
				newest_m = wr_m;
				wr_m     = (wr_m == 2'd2) ? 2'd0 : wr_m + 2'd1;
			end
		end

		// Let the last written frame run through the checker
		@(posedge video.vs);
		repeat (2) @(negedge clk_sys);
		$display("TEST OK");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Checker sampled at the falling edge
	////////////////////////////////////////////////////////////
	always @(negedge clk_sys) begin
		if (rst) begin
			vs_q        = 1'b0;
			hs_q        = 1'b0;
			hbl_q       = 1'b1;
			pix_idx     = 0;
			frames_seen = 0;
			line_px     = '0;
			line_cnt    = '0;
			hs_cnt      = '0;
		end else begin
			if (video.vs && !vs_q) begin
				// First vsync follows a partial raster
				if (frames_seen > 0) begin
					check_count("hs pulses per frame", hs_cnt, 9'd270);
					check_count("active lines per frame", line_cnt, 9'd102);
				end
				frames_seen = frames_seen + 1;
				hs_cnt      = '0;
				line_cnt    = '0;
				pix_idx     = 0;
			end
			if (video.hs && !hs_q) begin
				hs_cnt = hs_cnt + 9'd1;
			end
			if (video.hbl && !hbl_q && (line_px != 0)) begin
				check_count("active pixels per line", line_px, 9'd160);
				line_cnt = line_cnt + 9'd1;
				line_px  = '0;
			end
			if (video.ce_pix && !video.hbl && !video.vbl) begin
				check_rgb($sformatf("video.rgb pixel %0d", pix_idx), video.rgb,
					expected_rgb(pix_idx));
				pix_idx = pix_idx + 1;
				line_px = line_px + 9'd1;
			end
			vs_q  = video.vs;
			hs_q  = video.hs;
			hbl_q = video.hbl;
		end
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		abort_run("Watchdog expired before all frames were shown");
	end

endmodule
